// File: Bender.yml
package:
  name: wb_cache

sources:
  - cache_cfg_pkg.sv
  - cache_ctrl_pkg.sv
  - cache_ctrl_if.sv
  - ff_array.sv
  - cache_data_array.sv
  - cache_datapath.sv
  - cache_control.sv
  - cache_top.sv
  - target: test
    files:
      - pmem_model.sv
      - tb_cache.sv

// File: cache_cfg_pkg.sv
package cache_cfg_pkg;

    // Line geometry.
    localparam int OFFSET_W = 5;
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 32 - OFFSET_W - INDEX_W;
    localparam int MASK_W   = 2 ** OFFSET_W;
    localparam int LINE_W   = 8 * MASK_W;
    localparam int NUM_SETS = 2 ** INDEX_W;

    // Address is split as tag, index, offset from the top down.
    typedef logic [TAG_W+INDEX_W+OFFSET_W-1:0] addr_t;

    typedef logic [TAG_W-1:0] tag_t;

    typedef logic [INDEX_W-1:0] index_t;

    typedef logic [LINE_W-1:0] line_t;

    typedef logic [MASK_W-1:0] be_t;

endpackage

// File: cache_control.sv
`timescale 1ns/1ps

module cache_control (
    input  logic     clk,
    input  logic     rst_n,
    cache_ctrl_if.ctrl ctrl,

    input  logic     mem_read,
    input  logic     mem_write,
    output logic     mem_resp,

    input  logic     pmem_resp,
    output logic     pmem_read,
    output logic     pmem_write
);

    import cache_ctrl_pkg::*;

    cache_state_t state;
    cache_state_t state_next;
    logic         is_write;
    logic         pmem_read_next;
    logic         pmem_write_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            is_write   <= 1'b0;
            pmem_read  <= 1'b0;
            pmem_write <= 1'b0;
        end else begin
            state      <= state_next;
            pmem_read  <= pmem_read_next;
            pmem_write <= pmem_write_next;
            if (ctrl.capture) begin
                is_write <= mem_write;
            end
        end
    end

    always_comb begin
        state_next      = state;
        ctrl.capture    = 1'b0;
        ctrl.tag_we     = 1'b0;
        ctrl.valid_we   = 1'b0;
        ctrl.dirty_we   = 1'b0;
        ctrl.dirty_in   = 1'b0;
        ctrl.fill_sel   = FILL_NONE;
        pmem_read_next  = 1'b0;
        pmem_write_next = 1'b0;
        mem_resp        = 1'b0;

        case (state)
            IDLE: begin
                if (mem_read || mem_write) begin
                    ctrl.capture = 1'b1;
                    state_next   = LOOKUP;
                end
            end
            LOOKUP: begin
                if (ctrl.hit) begin
                    if (is_write) begin
                        ctrl.fill_sel = FILL_CPU;
                        ctrl.dirty_we = 1'b1;
                        ctrl.dirty_in = 1'b1;
                    end
                    state_next = RESPOND;
                end else if (ctrl.dirty) begin
                    pmem_write_next = 1'b1;
                    state_next      = WRITEBACK;
                end else begin
                    pmem_read_next = 1'b1;
                    state_next     = ALLOCATE;
                end
            end
            WRITEBACK: begin
                // Victim is clean once written, so the fill uses the request address.
                if (pmem_resp) begin
                    ctrl.dirty_we  = 1'b1;
                    pmem_read_next = 1'b1;
                    state_next     = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (pmem_resp) begin
                    ctrl.fill_sel = FILL_MEM;
                    ctrl.tag_we   = 1'b1;
                    ctrl.valid_we = 1'b1;
                    ctrl.dirty_we = 1'b1;
                    state_next    = LOOKUP;
                end
            end
            RESPOND: begin
                mem_resp   = 1'b1;
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

// File: cache_ctrl_if.sv
`timescale 1ns/1ps

interface cache_ctrl_if;

    import cache_ctrl_pkg::*;

    logic      capture;
    logic      tag_we;
    logic      valid_we;
    logic      dirty_we;
    logic      dirty_in;
    fill_sel_t fill_sel;

    // Status of the set selected by the captured request.
    logic      hit;
    logic      dirty;

    modport ctrl (
        output capture, tag_we, valid_we, dirty_we, dirty_in, fill_sel,
        input  hit, dirty
    );

    modport dp (
        input  capture, tag_we, valid_we, dirty_we, dirty_in, fill_sel,
        output hit, dirty
    );

endinterface

// File: cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        ALLOCATE,
        RESPOND
    } cache_state_t;

    // Source of data written into the line array.
    typedef enum logic [1:0] {
        FILL_MEM,
        FILL_CPU,
        FILL_NONE
    } fill_sel_t;

endpackage

// File: cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_cfg_pkg::be_t    wmask,
    input  cache_cfg_pkg::index_t addr,
    input  cache_cfg_pkg::line_t  din,
    output cache_cfg_pkg::line_t  dout
);

    import cache_cfg_pkg::*;

    line_t mem [NUM_SETS];

    // No writes while reset is held.
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (wmask[b]) begin
                    mem[addr][8*b +: 8] <= din[8*b +: 8];
                end
            end
        end
    end

    assign dout = mem[addr];

endmodule

// File: cache_datapath.sv
`timescale 1ns/1ps

module cache_datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    cache_ctrl_if.dp             ctrl,

    input  cache_cfg_pkg::addr_t mem_address,
    input  cache_cfg_pkg::line_t mem_wdata,
    input  cache_cfg_pkg::be_t   mem_byte_enable,
    output cache_cfg_pkg::line_t mem_rdata,

    input  cache_cfg_pkg::line_t pmem_rdata,
    output cache_cfg_pkg::addr_t pmem_address,
    output cache_cfg_pkg::line_t pmem_wdata
);

    import cache_cfg_pkg::*;
    import cache_ctrl_pkg::*;

    addr_t  req_addr;
    line_t  req_wdata;
    be_t    req_be;
    index_t req_index;
    tag_t   req_tag;

    tag_t   tag_out;
    logic   valid_out;
    be_t    write_mask;
    line_t  data_in;
    line_t  data_out;

    // Request held for the whole transaction.
    always_ff @(posedge clk) begin
        if (ctrl.capture) begin
            req_addr  <= mem_address;
            req_wdata <= mem_wdata;
            req_be    <= mem_byte_enable;
        end
    end

    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign req_tag   = req_addr[OFFSET_W+INDEX_W +: TAG_W];

    cache_data_array data_array (
        .clk   (clk),
        .rst_n (rst_n),
        .wmask (write_mask),
        .addr  (req_index),
        .din   (data_in),
        .dout  (data_out)
    );

    ff_array #(.payload_t(tag_t), .DEPTH(NUM_SETS)) tag_array (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (ctrl.tag_we),
        .addr  (req_index),
        .din   (req_tag),
        .dout  (tag_out)
    );

    ff_array #(.DEPTH(NUM_SETS)) valid_array (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (ctrl.valid_we),
        .addr  (req_index),
        .din   (1'b1),
        .dout  (valid_out)
    );

    ff_array #(.DEPTH(NUM_SETS)) dirty_array (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (ctrl.dirty_we),
        .addr  (req_index),
        .din   (ctrl.dirty_in),
        .dout  (ctrl.dirty)
    );

    assign ctrl.hit = (tag_out == req_tag) && valid_out;

    always_comb begin
        case (ctrl.fill_sel)
            FILL_MEM: begin
                write_mask = '1;
                data_in    = pmem_rdata;
            end
            FILL_CPU: begin
                write_mask = req_be;
                data_in    = req_wdata;
            end
            default: begin
                write_mask = '0;
                data_in    = req_wdata;
            end
        endcase
    end

    // A dirty victim is addressed by its own tag.
    always_comb begin
        if (ctrl.dirty) begin
            pmem_address = {tag_out, req_index, {OFFSET_W{1'b0}}};
        end else begin
            pmem_address = {req_tag, req_index, {OFFSET_W{1'b0}}};
        end
    end

    assign mem_rdata  = data_out;
    assign pmem_wdata = data_out;

endmodule

// File: cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 mem_read,
    input  logic                 mem_write,
    input  cache_cfg_pkg::addr_t mem_address,
    input  cache_cfg_pkg::line_t mem_wdata,
    input  cache_cfg_pkg::be_t   mem_byte_enable,
    output cache_cfg_pkg::line_t mem_rdata,
    output logic                 mem_resp,

    output logic                 pmem_read,
    output logic                 pmem_write,
    output cache_cfg_pkg::addr_t pmem_address,
    output cache_cfg_pkg::line_t pmem_wdata,
    input  cache_cfg_pkg::line_t pmem_rdata,
    input  logic                 pmem_resp
);

    cache_ctrl_if ctrl_if ();

    cache_control control (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_if.ctrl),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_resp   (mem_resp),
        .pmem_resp  (pmem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write)
    );

    cache_datapath datapath (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctrl            (ctrl_if.dp),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .mem_rdata       (mem_rdata),
        .pmem_rdata      (pmem_rdata),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata)
    );

endmodule

// File: ff_array.sv
`timescale 1ns/1ps

module ff_array #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = cache_cfg_pkg::NUM_SETS
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  we,
    input  cache_cfg_pkg::index_t addr,
    input  payload_t              din,
    output payload_t              dout
);

    payload_t mem [DEPTH];

    // Cleared entries read as invalid and clean.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= din;
        end
    end

    assign dout = mem[addr];

endmodule

// File: pmem_model.sv
`timescale 1ns/1ps

module pmem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pmem_read,
    input  logic                 pmem_write,
    input  cache_cfg_pkg::addr_t pmem_address,
    input  cache_cfg_pkg::line_t pmem_wdata,
    output cache_cfg_pkg::line_t pmem_rdata,
    output logic                 pmem_resp,
    output int                   read_count,
    output int                   write_count
);

    import cache_cfg_pkg::*;

    localparam int          MEM_LINES = 512;
    localparam logic [31:0] SEED      = 32'hcdb6_c42f;

    line_t       mem [MEM_LINES];
    logic [31:0] rand_state;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Lines are numbered by address bits 13:5.
    initial begin
        logic [8:0] line_idx;
        logic       is_write;
        line_t      wdata_q;
        int         latency;
        rand_state  = SEED;
        pmem_resp   = 1'b0;
        pmem_rdata  = '0;
        read_count  = 0;
        write_count = 0;
        for (int i = 0; i < MEM_LINES; i++) begin
            for (int w = 0; w < LINE_W / 32; w++) begin
                rand_state = next_rand(rand_state);
                mem[i][32*w +: 32] = rand_state;
            end
        end
        forever begin
            @(negedge clk);
            pmem_resp = 1'b0;
            if (rst_n && (pmem_read || pmem_write)) begin
                line_idx = pmem_address[13:5];
                is_write = pmem_write;
                wdata_q  = pmem_wdata;
                if (is_write) begin
                    write_count++;
                end else begin
                    read_count++;
                end
                rand_state = next_rand(rand_state);
                latency    = 1 + rand_state[23:16] % 6;
                repeat (latency) @(negedge clk);
                if (is_write) begin
                    mem[line_idx] = wdata_q;
                end else begin
                    pmem_rdata = mem[line_idx];
                end
                pmem_resp = 1'b1;
            end
        end
    end

endmodule

// File: tb_cache.sv
`timescale 1ns/1ps

module tb_cache;

    import cache_cfg_pkg::*;

    localparam int          TIMEOUT  = 100;
    localparam int          MAX_ROWS = 16;
    localparam logic [31:0] SEED     = 32'hcdb6_c42f;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  mem_read;
    logic  mem_write;
    addr_t mem_address;
    line_t mem_wdata;
    be_t   mem_byte_enable;
    line_t mem_rdata;
    logic  mem_resp;
    logic  pmem_read;
    logic  pmem_write;
    addr_t pmem_address;
    line_t pmem_wdata;
    line_t pmem_rdata;
    logic  pmem_resp;
    int    read_count;
    int    write_count;

    // Stimulus table.
    string row_name  [MAX_ROWS];
    logic  row_write [MAX_ROWS];
    addr_t row_addr  [MAX_ROWS];
    line_t row_data  [MAX_ROWS];
    be_t   row_be    [MAX_ROWS];
    logic  row_wb    [MAX_ROWS];
    int    num_rows;

    // Memory as the CPU sees it, plus the expected tag state per set.
    line_t       shadow    [512];
    logic        ref_valid [NUM_SETS];
    tag_t        ref_tag   [NUM_SETS];
    logic        ref_dirty [NUM_SETS];
    logic [31:0] rand_state;
    int          errors;
    int          pass_count;
    int          fail_count;

    always #20 clk = ~clk;

    cache_top DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .pmem_resp       (pmem_resp)
    );

    pmem_model mem_model (
        .clk          (clk),
        .rst_n        (rst_n),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .read_count   (read_count),
        .write_count  (write_count)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input string name, input logic wr, input addr_t addr,
                           input be_t be, input logic wb);
        row_name[num_rows]  = name;
        row_write[num_rows] = wr;
        row_addr[num_rows]  = addr;
        row_be[num_rows]    = be;
        row_wb[num_rows]    = wb;
        for (int w = 0; w < LINE_W / 32; w++) begin
            rand_state = next_rand(rand_state);
            row_data[num_rows][32*w +: 32] = rand_state;
        end
        num_rows++;
    endtask

    task automatic check_value(input string test, input string what,
                               input line_t expected, input line_t actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %0h actual %0h", test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_for_resp(output logic ok);
        int cycles;
        cycles = 0;
        while (mem_resp !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = (mem_resp === 1'b1);
    endtask

    initial begin
        logic [8:0] line_idx;
        logic [8:0] victim;
        index_t     set_idx;
        tag_t       req_tag;
        logic       hit;
        logic       exp_wb;
        logic       ok;
        int         rd0;
        int         wr0;
        rst_n           = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = '0;
        mem_wdata       = '0;
        mem_byte_enable = '0;
        num_rows        = 0;
        pass_count      = 0;
        fail_count      = 0;
        rand_state      = SEED;

        // Row data continues the sequence past the memory contents.
        for (int i = 0; i < 512 * (LINE_W / 32); i++) begin
            rand_state = next_rand(rand_state);
        end

        add_row("rd_cold_a",      1'b0, 32'h0000_0040, '0,             1'b0);
        add_row("rd_hit_a",       1'b0, 32'h0000_005c, '0,             1'b0);
        add_row("wr_hit_a",       1'b1, 32'h0000_0040, 32'h0000_f00f,  1'b0);
        add_row("rd_merge_a",     1'b0, 32'h0000_0040, '0,             1'b0);
        add_row("wr_miss_b",      1'b1, 32'h0000_0260, 32'hff00_00f0,  1'b0);
        add_row("rd_hit_b",       1'b0, 32'h0000_0260, '0,             1'b0);
        add_row("rd_evict_a",     1'b0, 32'h0000_0240, '0,             1'b1);
        add_row("rd_evict_b",     1'b0, 32'h0000_0460, '0,             1'b1);
        add_row("rd_clean_evict", 1'b0, 32'h0000_0640, '0,             1'b0);
        add_row("rd_back_a",      1'b0, 32'h0000_0040, '0,             1'b0);
        add_row("rd_back_b",      1'b0, 32'h0000_0260, '0,             1'b0);
        add_row("wr_miss_c",      1'b1, 32'h0000_3fe0, '1,             1'b0);
        add_row("wr_hit_c",       1'b1, 32'h0000_3fe0, 32'h0f0f_0f0f,  1'b0);
        add_row("wr_evict_c",     1'b1, 32'h0000_01e0, 32'h8000_0001,  1'b1);
        add_row("rd_back_c",      1'b0, 32'h0000_3fe0, '0,             1'b1);
        add_row("rd_back_d",      1'b0, 32'h0000_01e0, '0,             1'b0);

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < 512; i++) begin
            shadow[i] = mem_model.mem[i];
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_valid[s] = 1'b0;
            ref_tag[s]   = '0;
            ref_dirty[s] = 1'b0;
        end

        ok = 1'b1;
        for (int r = 0; r < num_rows && ok; r++) begin
            line_idx = row_addr[r][13:5];
            set_idx  = row_addr[r][OFFSET_W +: INDEX_W];
            req_tag  = row_addr[r][OFFSET_W+INDEX_W +: TAG_W];
            hit      = ref_valid[set_idx] && (ref_tag[set_idx] == req_tag);
            exp_wb   = !hit && ref_valid[set_idx] && ref_dirty[set_idx];
            victim   = {ref_tag[set_idx][4:0], set_idx};
            errors   = 0;

            @(negedge clk);
            rd0             = read_count;
            wr0             = write_count;
            mem_read        = !row_write[r];
            mem_write       = row_write[r];
            mem_address     = row_addr[r];
            mem_wdata       = row_data[r];
            mem_byte_enable = row_be[r];
            @(negedge clk);
            mem_read  = 1'b0;
            mem_write = 1'b0;
            wait_for_resp(ok);

            if (!ok) begin
                $display("Row %s got no mem_resp within %0d cycles", row_name[r], TIMEOUT);
                errors++;
            end else begin
                check_value(row_name[r], "table writeback flag", exp_wb, row_wb[r]);
                check_value(row_name[r], "pmem_write count", exp_wb, write_count - wr0);
                check_value(row_name[r], "pmem_read count", !hit, read_count - rd0);
                // The victim must now sit in memory at its old address.
                if (exp_wb) begin
                    check_value(row_name[r], "written-back line", shadow[victim],
                                mem_model.mem[victim]);
                end
                if (row_write[r]) begin
                    for (int b = 0; b < MASK_W; b++) begin
                        if (row_be[r][b]) begin
                            shadow[line_idx][8*b +: 8] = row_data[r][8*b +: 8];
                        end
                    end
                end else begin
                    check_value(row_name[r], "mem_rdata", shadow[line_idx], mem_rdata);
                end
            end

            ref_dirty[set_idx] = hit ? (ref_dirty[set_idx] | row_write[r]) : row_write[r];
            ref_valid[set_idx] = 1'b1;
            ref_tag[set_idx]   = req_tag;
            if (errors == 0) begin
                pass_count++;
                $display("row %s ok", row_name[r]);
            end else begin
                fail_count++;
                $display("row %s failed", row_name[r]);
            end
        end

        $display("rows passed: %0d, rows failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
cache_cfg_pkg.sv
cache_ctrl_pkg.sv
cache_ctrl_if.sv
ff_array.sv
cache_data_array.sv
cache_datapath.sv
cache_control.sv
cache_top.sv
pmem_model.sv
tb_cache.sv
